// File: src/coreDefs.sv
// ===================================================================
// Shared definitions for the integer slice
// Covers only the R2 and 16-bit immediate formats
// Opcode and function values exist for the kept integer subset only
// ===================================================================
`default_nettype none

package coreDefs;

	localparam int InstWidth   = 36;
	localparam int ValueWidth  = 64;
	localparam int RegCount    = 32;
	localparam int RegIdxWidth = 5;
	localparam int ImmWidth    = 16;

	// ===================================================================
	// Opcodes and R2 function codes
	localparam logic [7:0] R2    = 8'h02;
	localparam logic [7:0] ADDI  = 8'h04;
	localparam logic [7:0] SLTI  = 8'h06;
	localparam logic [7:0] SLTUI = 8'h07;
	localparam logic [7:0] ANDI  = 8'h08;
	localparam logic [7:0] ORI   = 8'h09;
	localparam logic [7:0] XORI  = 8'h0A;
	localparam logic [7:0] NOP   = 8'hF1;

	localparam logic [6:0] FnAdd  = 7'h04;
	localparam logic [6:0] FnSub  = 7'h05;
	localparam logic [6:0] FnSlt  = 7'h06;
	localparam logic [6:0] FnSltu = 7'h07;
	localparam logic [6:0] FnAnd  = 7'h08;
	localparam logic [6:0] FnOr   = 7'h09;
	localparam logic [6:0] FnXor  = 7'h0A;

	// ===================================================================
	// Instruction layout
	typedef struct packed {
		logic [6:0]             func;    // 35:29
		logic [3:0]             padHi;
		logic [RegIdxWidth-1:0] Rb;      // 24:20
		logic                   padRb;
		logic [RegIdxWidth-1:0] Ra;      // 18:14
		logic                   padRa;
		logic [RegIdxWidth-1:0] Rt;      // 12:8
		logic [7:0]             opcode;
	} r2Fmt;

	typedef struct packed {
		logic [ImmWidth-1:0]    imm;     // 35:20
		logic                   padRb;
		logic [RegIdxWidth-1:0] Ra;
		logic                   padRa;
		logic [RegIdxWidth-1:0] Rt;
		logic [7:0]             opcode;
	} riFmt;

	// Same word, two decodings picked by opcode
	typedef union packed {
		r2Fmt r2;
		riFmt ri;
	} instWord;

	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluXor,
		AluSlt,
		AluSltu
	} aluOp;

	typedef enum logic [1:0] {
		ExtSign,
		ExtOnes,
		ExtZero
	} ExtKind;

endpackage

`default_nettype wire

// File: src/stageLinks.sv
// ===================================================================
// Links between pipeline stages
// Plain level signals qualified by valid with no back-pressure
// ===================================================================
`timescale 1ns/10ps
`default_nettype none

interface decodedLink;
	logic                                valid;
	coreDefs::aluOp                      op;
	logic [coreDefs::RegIdxWidth-1:0]    ra;
	logic [coreDefs::RegIdxWidth-1:0]    rb;
	logic [coreDefs::RegIdxWidth-1:0]    rt;
	logic                                useImm;
	logic [coreDefs::ValueWidth-1:0]     imm;       // Already extended
	logic                                regWrite;
	logic                                illegal;

	modport source(output valid, op, ra, rb, rt, useImm, imm, regWrite, illegal);
	modport sink(input valid, op, ra, rb, rt, useImm, imm, regWrite, illegal);
endinterface

interface resultLink;
	logic                                valid;
	logic                                write;     // Register file update
	logic [coreDefs::RegIdxWidth-1:0]    rt;
	logic [coreDefs::ValueWidth-1:0]     value;
	logic                                illegal;

	modport source(output valid, write, rt, value, illegal);
	modport sink(input valid, write, rt, value, illegal);
endinterface

`default_nettype wire

// File: src/instDecode.sv
// ===================================================================
// Decode stage with outputs registered on the sampling edge
// Unknown opcodes and R2 functions flag illegal and never write
// ===================================================================
`timescale 1ns/10ps
`default_nettype none

module instDecode (
	input  logic              clk,
	input  logic              rstN,
	input  logic              instValid,
	input  coreDefs::instWord inst,
	decodedLink.source        dec
);

	coreDefs::aluOp                  nextOp;
	coreDefs::ExtKind                ext;
	logic                            isImm;
	logic                            nextUseImm;
	logic                            nextWrite;
	logic                            nextIllegal;
	logic [coreDefs::ValueWidth-1:0] immExt;

	assign isImm = inst.ri.opcode inside {coreDefs::ADDI, coreDefs::SLTI, coreDefs::SLTUI,
		coreDefs::ANDI, coreDefs::ORI, coreDefs::XORI};

	always_comb begin
		nextOp      = coreDefs::AluAdd;
		ext         = coreDefs::ExtZero;
		nextUseImm  = 1'b0;
		nextIllegal = 1'b1;    // Default is unimplemented
		case (inst.r2.opcode)
		coreDefs::R2: begin
			nextIllegal = 1'b0;
			case (inst.r2.func)
			coreDefs::FnAdd:  nextOp = coreDefs::AluAdd;
			coreDefs::FnSub:  nextOp = coreDefs::AluSub;
			coreDefs::FnAnd:  nextOp = coreDefs::AluAnd;
			coreDefs::FnOr:   nextOp = coreDefs::AluOr;
			coreDefs::FnXor:  nextOp = coreDefs::AluXor;
			coreDefs::FnSlt:  nextOp = coreDefs::AluSlt;
			coreDefs::FnSltu: nextOp = coreDefs::AluSltu;
			default:          nextIllegal = 1'b1;
			endcase
		end
		coreDefs::NOP:   nextIllegal = 1'b0;
		coreDefs::ADDI:  ext = coreDefs::ExtSign;
		coreDefs::SLTI: begin
			nextOp = coreDefs::AluSlt;
			ext    = coreDefs::ExtSign;
		end
		coreDefs::SLTUI: nextOp = coreDefs::AluSltu;    // Zero extended
		coreDefs::ANDI: begin
			nextOp = coreDefs::AluAnd;
			ext    = coreDefs::ExtOnes;                 // Keeps upper bits of Ra
		end
		coreDefs::ORI:   nextOp = coreDefs::AluOr;
		coreDefs::XORI:  nextOp = coreDefs::AluXor;
		default: ;
		endcase
		if (isImm) begin
			nextUseImm  = 1'b1;
			nextIllegal = 1'b0;
		end
		nextWrite = !nextIllegal && (inst.r2.opcode != coreDefs::NOP);
	end

	// Immediate widening
	always_comb begin
		case (ext)
		coreDefs::ExtSign:
			immExt = {{(coreDefs::ValueWidth-coreDefs::ImmWidth){inst.ri.imm[coreDefs::ImmWidth-1]}},
				inst.ri.imm};
		coreDefs::ExtOnes:
			immExt = {{(coreDefs::ValueWidth-coreDefs::ImmWidth){1'b1}}, inst.ri.imm};
		default:
			immExt = {{(coreDefs::ValueWidth-coreDefs::ImmWidth){1'b0}}, inst.ri.imm};
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			dec.valid    <= 1'b0;
			dec.regWrite <= 1'b0;
			dec.illegal  <= 1'b0;
		end else begin
			dec.valid    <= instValid;
			dec.regWrite <= instValid && nextWrite;
			dec.illegal  <= instValid && nextIllegal;
		end
	end

	always_ff @(posedge clk) begin
		dec.op     <= nextOp;
		dec.ra     <= inst.ri.Ra;
		dec.rb     <= inst.r2.Rb;     // Overlaps imm for immediate forms
		dec.rt     <= inst.r2.Rt;
		dec.useImm <= nextUseImm;
		dec.imm    <= immExt;
	end

endmodule

`default_nettype wire

// File: src/regFile.sv
// ===================================================================
// 32 x 64 register file with two async reads and one write
// Register 0 is never stored and every register reads zero after reset
// ===================================================================
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic [coreDefs::RegIdxWidth-1:0] raIdx,
	input  logic [coreDefs::RegIdxWidth-1:0] rbIdx,
	output logic [coreDefs::ValueWidth-1:0]  raVal,
	output logic [coreDefs::ValueWidth-1:0]  rbVal,
	resultLink.sink                          wb
);

	logic [coreDefs::ValueWidth-1:0] regs [coreDefs::RegCount];
	logic [coreDefs::RegCount-1:0]   written;    // Entry holds a value since reset

	assign raVal = written[raIdx] ? regs[raIdx] : '0;
	assign rbVal = written[rbIdx] ? regs[rbIdx] : '0;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			written <= '0;
		else if (wb.valid && wb.write && (wb.rt != '0))
			written[wb.rt] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (wb.valid && wb.write && (wb.rt != '0))
			regs[wb.rt] <= wb.value;
	end

endmodule

`default_nettype wire

// File: src/aluExecute.sv
// ===================================================================
// Execute stage that is combinational from the decode register
// Forwards only the result register; older results come from the file
// ===================================================================
`timescale 1ns/10ps
`default_nettype none

module aluExecute (
	decodedLink.sink                         dec,
	output logic [coreDefs::RegIdxWidth-1:0] raIdx,
	output logic [coreDefs::RegIdxWidth-1:0] rbIdx,
	input  logic [coreDefs::ValueWidth-1:0]  raVal,
	input  logic [coreDefs::ValueWidth-1:0]  rbVal,
	resultLink.sink                          fwd,
	output logic [coreDefs::ValueWidth-1:0]  value,
	output logic                             write
);

	logic                            fwdLive;
	logic [coreDefs::ValueWidth-1:0] opA;
	logic [coreDefs::ValueWidth-1:0] rbOperand;
	logic [coreDefs::ValueWidth-1:0] opB;

	assign raIdx = dec.ra;
	assign rbIdx = dec.rb;

	// ===================================================================
	// Operand bypass
	assign fwdLive   = fwd.write && (fwd.rt != '0);
	assign opA       = (fwdLive && (fwd.rt == dec.ra)) ? fwd.value : raVal;
	assign rbOperand = (fwdLive && (fwd.rt == dec.rb)) ? fwd.value : rbVal;
	assign opB       = dec.useImm ? dec.imm : rbOperand;

	always_comb begin
		case (dec.op)
		coreDefs::AluAdd:  value = opA + opB;
		coreDefs::AluSub:  value = opA - opB;
		coreDefs::AluAnd:  value = opA & opB;
		coreDefs::AluOr:   value = opA | opB;
		coreDefs::AluXor:  value = opA ^ opB;
		coreDefs::AluSlt:
			value = {{(coreDefs::ValueWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
		coreDefs::AluSltu:
			value = {{(coreDefs::ValueWidth-1){1'b0}}, opA < opB};
		default:           value = '0;
		endcase
	end

	assign write = dec.regWrite && (dec.rt != '0);    // R0 stays zero

endmodule

`default_nettype wire

// File: src/resultStage.sv
// ===================================================================
// Result register feeding write-back, the bypass and the outputs
// Illegal and NOP items carry a zero value
// ===================================================================
`timescale 1ns/10ps
`default_nettype none

module resultStage (
	input  logic                            clk,
	input  logic                            rstN,
	decodedLink.sink                        dec,
	input  logic [coreDefs::ValueWidth-1:0] value,
	input  logic                            write,
	resultLink.source                       res
);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			res.valid   <= 1'b0;
			res.write   <= 1'b0;
			res.illegal <= 1'b0;
		end else begin
			res.valid   <= dec.valid;
			res.write   <= dec.valid && write;
			res.illegal <= dec.valid && dec.illegal;
		end
	end

	always_ff @(posedge clk) begin
		res.rt    <= dec.rt;
		res.value <= (dec.valid && dec.regWrite) ? value : '0;
	end

endmodule

`default_nettype wire

// File: src/coreSlice.sv
// ===================================================================
// Integer slice top level
// One instruction per clock on instValid and no back-pressure
// Results appear two cycles after the sampling edge
// ===================================================================
`timescale 1ns/10ps
`default_nettype none

module coreSlice (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             instValid,
	input  logic [coreDefs::InstWidth-1:0]   inst,
	output logic                             resValid,
	output logic                             resIllegal,
	output logic [coreDefs::RegIdxWidth-1:0] resRt,
	output logic [coreDefs::ValueWidth-1:0]  resValue
);

	decodedLink decLink();
	resultLink  resLink();

	logic [coreDefs::RegIdxWidth-1:0] raIdx;
	logic [coreDefs::RegIdxWidth-1:0] rbIdx;
	logic [coreDefs::ValueWidth-1:0]  raVal;
	logic [coreDefs::ValueWidth-1:0]  rbVal;
	logic [coreDefs::ValueWidth-1:0]  exValue;
	logic                             exWrite;

	instDecode uDecode (
		.clk       (clk),
		.rstN      (rstN),
		.instValid (instValid),
		.inst      (inst),
		.dec       (decLink)
	);

	aluExecute uExecute (
		.dec   (decLink),
		.raIdx (raIdx),
		.rbIdx (rbIdx),
		.raVal (raVal),
		.rbVal (rbVal),
		.fwd   (resLink),
		.value (exValue),
		.write (exWrite)
	);

	regFile uRegs (
		.clk   (clk),
		.rstN  (rstN),
		.raIdx (raIdx),
		.rbIdx (rbIdx),
		.raVal (raVal),
		.rbVal (rbVal),
		.wb    (resLink)
	);

	resultStage uResult (
		.clk   (clk),
		.rstN  (rstN),
		.dec   (decLink),
		.value (exValue),
		.write (exWrite),
		.res   (resLink)
	);

	assign resValid   = resLink.valid;
	assign resIllegal = resLink.illegal;
	assign resRt      = resLink.rt;
	assign resValue   = resLink.value;

endmodule

`default_nettype wire

// File: tests/tbClock.sv
// ======================================================================
// Testbench clock and reset with a 40 ns period
// rstN is held low for three rising edges and released on a falling edge
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module tbClock (
	output logic clk,
	output logic rstN
);

	localparam time HalfPeriod = 20ns;

	initial begin
		clk = 1'b0;
		forever #(HalfPeriod) clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/coreSlice_assert.sv
// ======================================================================
// Reference model and concurrent checks bound into coreSlice
// The model sees only inst and instValid and keeps a shadow register file
// Expected results trail the sampling edge by two clocks
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module coreSlice_assert (
	input logic        clk,
	input logic        rstN,
	input logic        instValid,
	input logic [35:0] inst,
	input logic        resValid,
	input logic        resIllegal,
	input logic [4:0]  resRt,
	input logic [63:0] resValue
);

	logic [63:0] shadow [32];
	logic [63:0] srcA;
	logic [63:0] srcB;
	logic [63:0] sImm;
	logic [63:0] zImm;
	logic [63:0] result;
	logic        known;
	logic        writes;
	logic        exp1Valid;
	logic        exp2Valid;
	logic        exp1Ill;
	logic        exp2Ill;
	logic [4:0]  exp1Rt;
	logic [4:0]  exp2Rt;
	logic [63:0] exp1Val;
	logic [63:0] exp2Val;
	int          latencyErrors = 0;
	int          valueErrors = 0;
	int          illegalErrors = 0;
	int          rtErrors = 0;
	int          resetErrors = 0;

	// ======================================================================
	// Reference model
	always_comb begin
		srcA   = shadow[inst[18:14]];
		srcB   = shadow[inst[24:20]];
		sImm   = {{48{inst[35]}}, inst[35:20]};
		zImm   = {48'h0, inst[35:20]};
		known  = 1'b1;
		writes = 1'b1;
		result = '0;
		case (inst[7:0])
		coreDefs::R2:
			case (inst[35:29])
			coreDefs::FnAdd:  result = srcA + srcB;
			coreDefs::FnSub:  result = srcA - srcB;
			coreDefs::FnAnd:  result = srcA & srcB;
			coreDefs::FnOr:   result = srcA | srcB;
			coreDefs::FnXor:  result = srcA ^ srcB;
			coreDefs::FnSlt:  result = {63'h0, $signed(srcA) < $signed(srcB)};
			coreDefs::FnSltu: result = {63'h0, srcA < srcB};
			default:          known = 1'b0;
			endcase
		coreDefs::ADDI:  result = srcA + sImm;
		coreDefs::SLTI:  result = {63'h0, $signed(srcA) < $signed(sImm)};
		coreDefs::SLTUI: result = {63'h0, srcA < zImm};
		coreDefs::ANDI:  result = srcA & {48'hFFFF_FFFF_FFFF, inst[35:20]};    // Ones above imm
		coreDefs::ORI:   result = srcA | zImm;
		coreDefs::XORI:  result = srcA ^ zImm;
		coreDefs::NOP:   writes = 1'b0;
		default:         known = 1'b0;
		endcase
		if (!known) begin
			writes = 1'b0;
			result = '0;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				shadow[i] <= '0;
			exp1Valid <= 1'b0;
			exp2Valid <= 1'b0;
			exp1Ill   <= 1'b0;
			exp2Ill   <= 1'b0;
		end else begin
			exp1Valid <= instValid;
			exp1Ill   <= instValid && !known;
			exp1Rt    <= inst[12:8];
			exp1Val   <= result;
			exp2Valid <= exp1Valid;
			exp2Ill   <= exp1Ill;
			exp2Rt    <= exp1Rt;
			exp2Val   <= exp1Val;
			if (instValid && writes && (inst[12:8] != 5'd0))
				shadow[inst[12:8]] <= result;    // R0 never changes
		end
	end

	// ======================================================================
	// Checks
	resetQuiet: assert property (@(posedge clk) !rstN |-> !resValid && !resIllegal)
	else begin
		resetErrors++;
		$error("** Error resetQuiet: expected 0/0 actual %0b/%0b",
			$sampled(resValid), $sampled(resIllegal));
	end

	latency: assert property (@(posedge clk) disable iff (!rstN) resValid == exp2Valid)
	else begin
		latencyErrors++;
		$error("** Error latency: expected %0b actual %0b",
			$sampled(exp2Valid), $sampled(resValid));
	end

	resultValue: assert property (@(posedge clk) disable iff (!rstN)
		resValid |-> resValue == exp2Val)
	else begin
		valueErrors++;
		$error("** Error resultValue: expected %h actual %h",
			$sampled(exp2Val), $sampled(resValue));
	end

	illegalFlag: assert property (@(posedge clk) disable iff (!rstN)
		resIllegal == (exp2Valid && exp2Ill))
	else begin
		illegalErrors++;
		$error("** Error illegalFlag: expected %0b actual %0b",
			$sampled(exp2Valid && exp2Ill), $sampled(resIllegal));
	end

	resultRt: assert property (@(posedge clk) disable iff (!rstN) resValid |-> resRt == exp2Rt)
	else begin
		rtErrors++;
		$error("** Error resultRt: expected %0d actual %0d", $sampled(exp2Rt), $sampled(resRt));
	end

endmodule

bind coreSlice coreSlice_assert uChecker (
	.clk        (clk),
	.rstN       (rstN),
	.instValid  (instValid),
	.inst       (inst),
	.resValid   (resValid),
	.resIllegal (resIllegal),
	.resRt      (resRt),
	.resValue   (resValue)
);

`default_nettype wire

// File: tests/coreSlice_tb.sv
// ======================================================================
// Testbench for coreSlice with inputs driven on falling edges
// Results are checked by the bound reference model
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module coreSlice_tb;

	logic        clk;
	logic        rstN;
	logic        instValid;
	logic [35:0] inst;
	logic        resValid;
	logic        resIllegal;
	logic [4:0]  resRt;
	logic [63:0] resValue;
	logic [31:0] rngState = 32'h18bcd809;
	int          timeoutErrors = 0;
	int          totalErrors;

	tbClock uClock (
		.clk  (clk),
		.rstN (rstN)
	);

	coreSlice UUT (
		.clk        (clk),
		.rstN       (rstN),
		.instValid  (instValid),
		.inst       (inst),
		.resValid   (resValid),
		.resIllegal (resIllegal),
		.resRt      (resRt),
		.resValue   (resValue)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	function automatic logic [35:0] r2Inst(input logic [6:0] fn, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb);
		return {fn, 4'h0, rb, 1'b0, ra, 1'b0, rt, coreDefs::R2};
	endfunction

	function automatic logic [35:0] riInst(input logic [7:0] op, input logic [4:0] rt,
		input logic [4:0] ra, input logic [15:0] imm);
		return {imm, 1'b0, ra, 1'b0, rt, op};
	endfunction

	function automatic logic [6:0] pickFunc(input logic [31:0] r);
		case (r[18:16])
		3'd0:    return coreDefs::FnAdd;
		3'd1:    return coreDefs::FnSub;
		3'd2:    return coreDefs::FnAnd;
		3'd3:    return coreDefs::FnOr;
		3'd4:    return coreDefs::FnXor;
		3'd5:    return coreDefs::FnSlt;
		default: return coreDefs::FnSltu;
		endcase
	endfunction

	function automatic logic [7:0] pickImmOp(input logic [31:0] r);
		case (r[18:16])
		3'd0:    return coreDefs::ADDI;
		3'd1:    return coreDefs::SLTI;
		3'd2:    return coreDefs::SLTUI;
		3'd3:    return coreDefs::ANDI;
		3'd4:    return coreDefs::ORI;
		default: return coreDefs::XORI;
		endcase
	endfunction

	task automatic issue(input logic [35:0] word);
		@(negedge clk);
		instValid = 1'b1;
		inst      = word;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			instValid = 1'b0;
			inst      = {4'h0, nextRand()};    // Junk must be ignored
		end
	endtask

	task automatic waitReset();
		int cycles;
		cycles = 0;
		while (!rstN && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (!rstN) begin
			$display("Reset was still asserted after %0d cycles", cycles);
			timeoutErrors++;
		end
	endtask

	// Waits until resValid has stayed low for four cycles
	task automatic drain();
		int quiet;
		int cycles;
		quiet  = 0;
		cycles = 0;
		idle(1);
		while (quiet < 4 && cycles < 40) begin
			@(negedge clk);
			cycles++;
			if (resValid)
				quiet = 0;
			else
				quiet++;
		end
		if (quiet < 4) begin
			$display("Pipeline did not drain within %0d cycles", cycles);
			timeoutErrors++;
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] s;
		logic [4:0]  rt;
		logic [4:0]  prev;
		logic [4:0]  prev2;
		instValid = 1'b0;
		inst      = '0;
		waitReset();

		// ======================================================================
		// Seed registers, then random R2 and immediate traffic with gaps
		for (int k = 1; k < 32; k++) begin
			r = nextRand();
			issue(riInst(coreDefs::ADDI, 5'(k), 5'd0, r[15:0]));
		end
		for (int k = 0; k < 60; k++) begin
			r = nextRand();
			s = nextRand();
			if (r[31])
				issue(r2Inst(pickFunc(r), r[4:0], r[9:5], r[14:10]));
			else
				issue(riInst(pickImmOp(r), r[4:0], r[9:5], s[15:0]));    // s[15] set half the time
			if (r[22:20] == 3'd0)
				idle(1 + int'(r[24:23]));
		end

		// ======================================================================
		// Dependent chains with no gaps to exercise the bypass and file reads
		prev  = 5'd1;
		prev2 = 5'd2;
		for (int k = 0; k < 24; k++) begin
			r  = nextRand();
			s  = nextRand();
			rt = (r[4:0] == 5'd0) ? 5'd9 : r[4:0];
			if (r[31])
				issue(r2Inst(pickFunc(r), rt, prev, prev2));
			else
				issue(riInst(pickImmOp(r), rt, prev, s[15:0]));
			prev2 = prev;
			prev  = rt;
		end

		// ======================================================================
		// R0 writes, NOP and illegal words followed by readers
		issue(riInst(coreDefs::ADDI, 5'd0, 5'd5, 16'h1234));
		issue(r2Inst(coreDefs::FnAdd, 5'd0, 5'd1, 5'd2));
		issue(r2Inst(coreDefs::FnOr, 5'd3, 5'd0, 5'd0));    // R0 still zero
		issue(riInst(coreDefs::NOP, 5'd4, 5'd4, 16'hFFFF));
		issue(r2Inst(coreDefs::FnOr, 5'd6, 5'd4, 5'd0));
		issue(riInst(8'h33, 5'd5, 5'd5, 16'h7777));
		issue(r2Inst(7'h7F, 5'd5, 5'd1, 5'd2));
		issue(r2Inst(7'h00, 5'd5, 5'd2, 5'd1));
		issue(r2Inst(coreDefs::FnAdd, 5'd7, 5'd5, 5'd0));    // r5 unchanged
		drain();

		totalErrors = UUT.uChecker.latencyErrors + UUT.uChecker.valueErrors
			+ UUT.uChecker.illegalErrors + UUT.uChecker.rtErrors
			+ UUT.uChecker.resetErrors + timeoutErrors;
		$display("Error counts: latency %0d value %0d illegal %0d rt %0d reset %0d timeout %0d",
			UUT.uChecker.latencyErrors, UUT.uChecker.valueErrors, UUT.uChecker.illegalErrors,
			UUT.uChecker.rtErrors, UUT.uChecker.resetErrors, timeoutErrors);
		if (totalErrors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
src/coreDefs.sv
src/stageLinks.sv
src/instDecode.sv
src/regFile.sv
src/aluExecute.sv
src/resultStage.sv
src/coreSlice.sv
tests/tbClock.sv
tests/coreSlice_assert.sv
tests/coreSlice_tb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the coreSlice testbench with Verilator.
# Exit status is 0 only when the testbench reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module coreSlice_tb -o coreSliceSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/coreSliceSim +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
